// File: common/ex_pkg.sv
package ex_pkg;

	localparam int xlen = 32;

	typedef logic [4:0] reg_addr_t;  // x0 is never written
	typedef logic [xlen-1:0] data_t;
	typedef logic [2:0] thread_id_t;  // up to eight threads

	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or  = 3'd3,
		op_xor = 3'd4,
		op_beq = 3'd5,
		op_bne = 3'd6
	} alu_op_e;

	function automatic logic is_branch(alu_op_e op);
		return (op == op_beq) || (op == op_bne);
	endfunction

endpackage

// File: queue/thread_queue.sv
`timescale 1ns/1ps

module thread_queue #(
	parameter int queue_depth = 3
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              issue_req,
	input  ex_pkg::alu_op_e   issue_op,
	input  ex_pkg::reg_addr_t issue_rd,
	input  ex_pkg::reg_addr_t issue_rs1,
	input  ex_pkg::reg_addr_t issue_rs2,
	input  ex_pkg::data_t     issue_op1,
	input  ex_pkg::data_t     issue_op2,
	input  ex_pkg::data_t     issue_pc,
	input  ex_pkg::data_t     issue_imm,
	output logic              issue_ack,
	input  logic              pop,
	input  logic              wb_valid,
	input  ex_pkg::reg_addr_t wb_addr,
	input  ex_pkg::data_t     wb_data,
	input  logic              jump_en,
	output logic              head_valid,
	output ex_pkg::alu_op_e   head_op,
	output ex_pkg::reg_addr_t head_rd,
	output ex_pkg::data_t     head_op1,
	output ex_pkg::data_t     head_op2,
	output ex_pkg::data_t     head_pc,
	output ex_pkg::data_t     head_imm
);
	import ex_pkg::*;

	localparam int cnt_w = $clog2(queue_depth + 1);

	// entry 0 is the oldest instruction
	alu_op_e   q_op  [queue_depth-1:0];
	reg_addr_t q_rd  [queue_depth-1:0];
	reg_addr_t q_rs1 [queue_depth-1:0];
	reg_addr_t q_rs2 [queue_depth-1:0];
	data_t     q_op1 [queue_depth-1:0];
	data_t     q_op2 [queue_depth-1:0];
	data_t     q_pc  [queue_depth-1:0];
	data_t     q_imm [queue_depth-1:0];

	alu_op_e   n_op  [queue_depth-1:0];
	reg_addr_t n_rd  [queue_depth-1:0];
	reg_addr_t n_rs1 [queue_depth-1:0];
	reg_addr_t n_rs2 [queue_depth-1:0];
	data_t     n_op1 [queue_depth-1:0];
	data_t     n_op2 [queue_depth-1:0];
	data_t     n_pc  [queue_depth-1:0];
	data_t     n_imm [queue_depth-1:0];

	data_t     fwd_op1 [queue_depth-1:0];
	data_t     fwd_op2 [queue_depth-1:0];
	data_t     in_op1;
	data_t     in_op2;

	logic [cnt_w-1:0] cnt;
	logic [cnt_w-1:0] wr_idx;
	logic             room;
	logic             acc;
	logic             br_pend;  // own branch between pop and result

	function automatic data_t fwd(reg_addr_t rs, data_t val);
		if (wb_valid && wb_addr != '0 && wb_addr == rs) begin
			return wb_data;
		end
		return val;
	endfunction

	always_comb begin
		for (int j = 0; j < queue_depth; j++) begin
			fwd_op1[j] = fwd(q_rs1[j], q_op1[j]);
			fwd_op2[j] = fwd(q_rs2[j], q_op2[j]);
		end
		in_op1 = fwd(issue_rs1, issue_op1);
		in_op2 = fwd(issue_rs2, issue_op2);
	end

	// a pop at the same edge frees the head slot
	assign room   = (cnt < cnt_w'(queue_depth)) || pop;
	assign acc    = issue_req && !issue_ack && room && !jump_en;
	assign wr_idx = pop ? cnt - 1'b1 : cnt;

	always_comb begin
		for (int j = 0; j < queue_depth; j++) begin
			n_op[j]  = q_op[j];
			n_rd[j]  = q_rd[j];
			n_rs1[j] = q_rs1[j];
			n_rs2[j] = q_rs2[j];
			n_op1[j] = fwd_op1[j];
			n_op2[j] = fwd_op2[j];
			n_pc[j]  = q_pc[j];
			n_imm[j] = q_imm[j];
		end
		if (pop) begin
			for (int j = 0; j < queue_depth - 1; j++) begin  // shift toward head
				n_op[j]  = q_op[j+1];
				n_rd[j]  = q_rd[j+1];
				n_rs1[j] = q_rs1[j+1];
				n_rs2[j] = q_rs2[j+1];
				n_op1[j] = fwd_op1[j+1];
				n_op2[j] = fwd_op2[j+1];
				n_pc[j]  = q_pc[j+1];
				n_imm[j] = q_imm[j+1];
			end
		end
		if (acc) begin
			n_op[wr_idx]  = issue_op;
			n_rd[wr_idx]  = issue_rd;
			n_rs1[wr_idx] = issue_rs1;
			n_rs2[wr_idx] = issue_rs2;
			n_op1[wr_idx] = in_op1;
			n_op2[wr_idx] = in_op2;
			n_pc[wr_idx]  = issue_pc;
			n_imm[wr_idx] = issue_imm;
		end
	end

	always_ff @(posedge clk) begin
		for (int j = 0; j < queue_depth; j++) begin
			q_op[j]  <= n_op[j];
			q_rd[j]  <= n_rd[j];
			q_rs1[j] <= n_rs1[j];
			q_rs2[j] <= n_rs2[j];
			q_op1[j] <= n_op1[j];
			q_op2[j] <= n_op2[j];
			q_pc[j]  <= n_pc[j];
			q_imm[j] <= n_imm[j];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			cnt       <= '0;
			issue_ack <= 1'b0;
			br_pend   <= 1'b0;
		end else begin
			if (jump_en) begin
				cnt <= '0;  // taken branch drops the wrong path
			end else begin
				cnt <= cnt + cnt_w'(acc) - cnt_w'(pop);
			end
			if (acc) begin
				issue_ack <= 1'b1;
			end else if (!issue_req) begin
				issue_ack <= 1'b0;
			end
			br_pend <= pop && is_branch(q_op[0]);  // result always one cycle later
		end
	end

	assign head_valid = (cnt != '0) && !br_pend;
	assign head_op    = q_op[0];
	assign head_rd    = q_rd[0];
	assign head_op1   = fwd_op1[0];  // bypass same-cycle writeback
	assign head_op2   = fwd_op2[0];
	assign head_pc    = q_pc[0];
	assign head_imm   = q_imm[0];

endmodule

// File: logic/dispatch_select.sv
`timescale 1ns/1ps

module dispatch_select #(
	parameter int num_threads = 4,
	parameter int num_alus    = 2
) (
	input  logic               dispatch_valid  [num_alus-1:0],
	input  ex_pkg::thread_id_t dispatch_thread [num_alus-1:0],
	input  logic               head_valid [num_threads-1:0],
	input  ex_pkg::alu_op_e    head_op    [num_threads-1:0],
	input  ex_pkg::reg_addr_t  head_rd    [num_threads-1:0],
	input  ex_pkg::data_t      head_op1   [num_threads-1:0],
	input  ex_pkg::data_t      head_op2   [num_threads-1:0],
	input  ex_pkg::data_t      head_pc    [num_threads-1:0],
	input  ex_pkg::data_t      head_imm   [num_threads-1:0],
	output logic               slot_valid  [num_alus-1:0],
	output ex_pkg::thread_id_t slot_thread [num_alus-1:0],
	output ex_pkg::alu_op_e    slot_op     [num_alus-1:0],
	output ex_pkg::reg_addr_t  slot_rd     [num_alus-1:0],
	output ex_pkg::data_t      slot_op1    [num_alus-1:0],
	output ex_pkg::data_t      slot_op2    [num_alus-1:0],
	output ex_pkg::data_t      slot_pc     [num_alus-1:0],
	output ex_pkg::data_t      slot_imm    [num_alus-1:0],
	output logic               pop [num_threads-1:0]
);
	import ex_pkg::*;

	always_comb begin
		for (int k = 0; k < num_alus; k++) begin
			slot_valid[k]  = 1'b0;  // unknown thread ids stay idle
			slot_thread[k] = dispatch_thread[k];
			slot_op[k]     = op_add;
			slot_rd[k]     = '0;
			slot_op1[k]    = '0;
			slot_op2[k]    = '0;
			slot_pc[k]     = '0;
			slot_imm[k]    = '0;
			for (int t = 0; t < num_threads; t++) begin
				if (dispatch_thread[k] == t) begin
					slot_valid[k] = dispatch_valid[k] && head_valid[t];
					slot_op[k]    = head_op[t];
					slot_rd[k]    = head_rd[t];
					slot_op1[k]   = head_op1[t];
					slot_op2[k]   = head_op2[t];
					slot_pc[k]    = head_pc[t];
					slot_imm[k]   = head_imm[t];
				end
			end
		end
	end

	always_comb begin
		for (int t = 0; t < num_threads; t++) begin
			pop[t] = 1'b0;
			for (int k = 0; k < num_alus; k++) begin
				if (slot_valid[k] && slot_thread[k] == t) begin
					pop[t] = 1'b1;
				end
			end
		end
	end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic              slot_valid,
	input  ex_pkg::alu_op_e   slot_op,
	input  ex_pkg::reg_addr_t slot_rd,
	input  ex_pkg::data_t     slot_op1,
	input  ex_pkg::data_t     slot_op2,
	input  ex_pkg::data_t     slot_pc,
	input  ex_pkg::data_t     slot_imm,
	output logic              res_wen,
	output ex_pkg::reg_addr_t res_rd,
	output ex_pkg::data_t     res_data,
	output logic              res_jump,
	output ex_pkg::data_t     res_jump_addr
);
	import ex_pkg::*;

	logic arith;
	logic taken;

	always_comb begin
		arith    = 1'b1;
		taken    = 1'b0;
		res_data = '0;
		case (slot_op)
			op_add: res_data = slot_op1 + slot_op2;
			op_sub: res_data = slot_op1 - slot_op2;
			op_and: res_data = slot_op1 & slot_op2;
			op_or:  res_data = slot_op1 | slot_op2;
			op_xor: res_data = slot_op1 ^ slot_op2;
			op_beq: begin
				arith = 1'b0;
				taken = (slot_op1 == slot_op2);
			end
			op_bne: begin
				arith = 1'b0;
				taken = (slot_op1 != slot_op2);
			end
			default: arith = 1'b0;
		endcase
	end

	assign res_wen       = slot_valid && arith && (slot_rd != '0);
	assign res_rd        = slot_rd;
	assign res_jump      = slot_valid && taken;
	assign res_jump_addr = slot_pc + slot_imm;  // pc relative target

endmodule

// File: logic/result_route.sv
`timescale 1ns/1ps

module result_route #(
	parameter int num_threads = 4,
	parameter int num_alus    = 2
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               slot_valid    [num_alus-1:0],
	input  ex_pkg::thread_id_t slot_thread   [num_alus-1:0],
	input  logic               res_wen       [num_alus-1:0],
	input  ex_pkg::reg_addr_t  res_rd        [num_alus-1:0],
	input  ex_pkg::data_t      res_data      [num_alus-1:0],
	input  logic               res_jump      [num_alus-1:0],
	input  ex_pkg::data_t      res_jump_addr [num_alus-1:0],
	output logic               wb_valid  [num_threads-1:0],
	output ex_pkg::reg_addr_t  wb_addr   [num_threads-1:0],
	output ex_pkg::data_t      wb_data   [num_threads-1:0],
	output logic               jump_en   [num_threads-1:0],
	output ex_pkg::data_t      jump_addr [num_threads-1:0]
);

	always_ff @(posedge clk) begin
		for (int t = 0; t < num_threads; t++) begin
			wb_valid[t]  <= 1'b0;  // one cycle pulse per dispatch
			wb_addr[t]   <= '0;
			wb_data[t]   <= '0;
			jump_en[t]   <= 1'b0;
			jump_addr[t] <= '0;
		end
		if (rst) begin
			for (int k = 0; k < num_alus; k++) begin
				for (int t = 0; t < num_threads; t++) begin
					if (slot_valid[k] && slot_thread[k] == t) begin
						wb_valid[t]  <= res_wen[k];
						wb_addr[t]   <= res_rd[k];
						wb_data[t]   <= res_data[k];
						jump_en[t]   <= res_jump[k];
						jump_addr[t] <= res_jump_addr[k];
					end
				end
			end
		end
	end

endmodule

// File: logic/ex_top.sv
`timescale 1ns/1ps

module ex_top #(
	parameter int num_threads = 4,
	parameter int num_alus    = 2,
	parameter int queue_depth = 3
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               issue_req [num_threads-1:0],
	input  ex_pkg::alu_op_e    issue_op  [num_threads-1:0],
	input  ex_pkg::reg_addr_t  issue_rd  [num_threads-1:0],
	input  ex_pkg::reg_addr_t  issue_rs1 [num_threads-1:0],
	input  ex_pkg::reg_addr_t  issue_rs2 [num_threads-1:0],
	input  ex_pkg::data_t      issue_op1 [num_threads-1:0],
	input  ex_pkg::data_t      issue_op2 [num_threads-1:0],
	input  ex_pkg::data_t      issue_pc  [num_threads-1:0],
	input  ex_pkg::data_t      issue_imm [num_threads-1:0],
	input  logic               dispatch_valid  [num_alus-1:0],
	input  ex_pkg::thread_id_t dispatch_thread [num_alus-1:0],
	output logic               issue_ack  [num_threads-1:0],
	output logic               head_valid [num_threads-1:0],
	output logic               wb_valid   [num_threads-1:0],
	output ex_pkg::reg_addr_t  wb_addr    [num_threads-1:0],
	output ex_pkg::data_t      wb_data    [num_threads-1:0],
	output logic               jump_en    [num_threads-1:0],
	output ex_pkg::data_t      jump_addr  [num_threads-1:0]
);
	import ex_pkg::*;

	alu_op_e    head_op  [num_threads-1:0];
	reg_addr_t  head_rd  [num_threads-1:0];
	data_t      head_op1 [num_threads-1:0];
	data_t      head_op2 [num_threads-1:0];
	data_t      head_pc  [num_threads-1:0];
	data_t      head_imm [num_threads-1:0];
	logic       pop      [num_threads-1:0];

	logic       slot_valid  [num_alus-1:0];
	thread_id_t slot_thread [num_alus-1:0];
	alu_op_e    slot_op     [num_alus-1:0];
	reg_addr_t  slot_rd     [num_alus-1:0];
	data_t      slot_op1    [num_alus-1:0];
	data_t      slot_op2    [num_alus-1:0];
	data_t      slot_pc     [num_alus-1:0];
	data_t      slot_imm    [num_alus-1:0];

	logic       res_wen       [num_alus-1:0];
	reg_addr_t  res_rd        [num_alus-1:0];
	data_t      res_data      [num_alus-1:0];
	logic       res_jump      [num_alus-1:0];
	data_t      res_jump_addr [num_alus-1:0];

	for (genvar t = 0; t < num_threads; t++) begin : g_queue
		thread_queue #(
			.queue_depth(queue_depth)
		) u_thread_queue (
			.clk       (clk),
			.rst       (rst),
			.issue_req (issue_req[t]),
			.issue_op  (issue_op[t]),
			.issue_rd  (issue_rd[t]),
			.issue_rs1 (issue_rs1[t]),
			.issue_rs2 (issue_rs2[t]),
			.issue_op1 (issue_op1[t]),
			.issue_op2 (issue_op2[t]),
			.issue_pc  (issue_pc[t]),
			.issue_imm (issue_imm[t]),
			.issue_ack (issue_ack[t]),
			.pop       (pop[t]),
			.wb_valid  (wb_valid[t]),
			.wb_addr   (wb_addr[t]),
			.wb_data   (wb_data[t]),
			.jump_en   (jump_en[t]),
			.head_valid(head_valid[t]),
			.head_op   (head_op[t]),
			.head_rd   (head_rd[t]),
			.head_op1  (head_op1[t]),
			.head_op2  (head_op2[t]),
			.head_pc   (head_pc[t]),
			.head_imm  (head_imm[t])
		);
	end

	dispatch_select #(
		.num_threads(num_threads),
		.num_alus   (num_alus)
	) u_dispatch_select (
		.dispatch_valid (dispatch_valid),
		.dispatch_thread(dispatch_thread),
		.head_valid     (head_valid),
		.head_op        (head_op),
		.head_rd        (head_rd),
		.head_op1       (head_op1),
		.head_op2       (head_op2),
		.head_pc        (head_pc),
		.head_imm       (head_imm),
		.slot_valid     (slot_valid),
		.slot_thread    (slot_thread),
		.slot_op        (slot_op),
		.slot_rd        (slot_rd),
		.slot_op1       (slot_op1),
		.slot_op2       (slot_op2),
		.slot_pc        (slot_pc),
		.slot_imm       (slot_imm),
		.pop            (pop)
	);

	for (genvar k = 0; k < num_alus; k++) begin : g_alu
		alu u_alu (
			.slot_valid   (slot_valid[k]),
			.slot_op      (slot_op[k]),
			.slot_rd      (slot_rd[k]),
			.slot_op1     (slot_op1[k]),
			.slot_op2     (slot_op2[k]),
			.slot_pc      (slot_pc[k]),
			.slot_imm     (slot_imm[k]),
			.res_wen      (res_wen[k]),
			.res_rd       (res_rd[k]),
			.res_data     (res_data[k]),
			.res_jump     (res_jump[k]),
			.res_jump_addr(res_jump_addr[k])
		);
	end

	result_route #(
		.num_threads(num_threads),
		.num_alus   (num_alus)
	) u_result_route (
		.clk          (clk),
		.rst          (rst),
		.slot_valid   (slot_valid),
		.slot_thread  (slot_thread),
		.res_wen      (res_wen),
		.res_rd       (res_rd),
		.res_data     (res_data),
		.res_jump     (res_jump),
		.res_jump_addr(res_jump_addr),
		.wb_valid     (wb_valid),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.jump_en      (jump_en),
		.jump_addr    (jump_addr)
	);

endmodule

// File: sim/ex_sva.sv
`timescale 1ns/1ps

module ex_sva #(
	parameter int num_threads = 4,
	parameter int num_alus    = 2
) (
	input logic               clk,
	input logic               rst,
	input logic               issue_req       [num_threads-1:0],
	input logic               issue_ack       [num_threads-1:0],
	input logic               dispatch_valid  [num_alus-1:0],
	input ex_pkg::thread_id_t dispatch_thread [num_alus-1:0],
	input logic               wb_valid        [num_threads-1:0],
	input ex_pkg::reg_addr_t  wb_addr         [num_threads-1:0]
);

	for (genvar t = 0; t < num_threads; t++) begin : g_thread
		a_ack_fall: assert property (@(posedge clk) disable iff (!rst)
			$fell(issue_ack[t]) |-> !$past(issue_req[t]))
			else $error("issue_ack of thread %0d fell while issue_req was high", t);
		a_wb_addr: assert property (@(posedge clk) disable iff (!rst)
			wb_valid[t] |-> wb_addr[t] != '0)
			else $error("writeback to x0 on thread %0d", t);
	end

	// scheduler must not name one thread twice
	for (genvar k = 0; k < num_alus; k++) begin : g_slot
		for (genvar j = k + 1; j < num_alus; j++) begin : g_pair
			a_one_thread: assert property (@(posedge clk) disable iff (!rst)
				dispatch_valid[k] && dispatch_valid[j] |-> dispatch_thread[k] != dispatch_thread[j])
				else $error("slots %0d and %0d name the same thread", k, j);
		end
	end

endmodule

bind ex_top ex_sva #(
	.num_threads(num_threads),
	.num_alus   (num_alus)
) u_ex_sva (
	.clk            (clk),
	.rst            (rst),
	.issue_req      (issue_req),
	.issue_ack      (issue_ack),
	.dispatch_valid (dispatch_valid),
	.dispatch_thread(dispatch_thread),
	.wb_valid       (wb_valid),
	.wb_addr        (wb_addr)
);

// File: sim/tb_ex_top.sv
`timescale 1ns/1ps

module tb_ex_top;
	import ex_pkg::*;

	localparam int num_threads = 4;
	localparam int num_alus    = 2;
	localparam int max_cycles  = 2000;  // tests take well under 600

	logic       clk;
	logic       rst;
	logic       issue_req  [num_threads-1:0];
	alu_op_e    issue_op   [num_threads-1:0];
	reg_addr_t  issue_rd   [num_threads-1:0];
	reg_addr_t  issue_rs1  [num_threads-1:0];
	reg_addr_t  issue_rs2  [num_threads-1:0];
	data_t      issue_op1  [num_threads-1:0];
	data_t      issue_op2  [num_threads-1:0];
	data_t      issue_pc   [num_threads-1:0];
	data_t      issue_imm  [num_threads-1:0];
	logic       dispatch_valid  [num_alus-1:0];
	thread_id_t dispatch_thread [num_alus-1:0];
	logic       issue_ack  [num_threads-1:0];
	logic       head_valid [num_threads-1:0];
	logic       wb_valid   [num_threads-1:0];
	reg_addr_t  wb_addr    [num_threads-1:0];
	data_t      wb_data    [num_threads-1:0];
	logic       jump_en    [num_threads-1:0];
	data_t      jump_addr  [num_threads-1:0];

	integer seed;
	int     cycles = 0;

	ex_top #(
		.num_threads(num_threads),
		.num_alus   (num_alus),
		.queue_depth(3)
	) u_ex_top (
		.clk            (clk),
		.rst            (rst),
		.issue_req      (issue_req),
		.issue_op       (issue_op),
		.issue_rd       (issue_rd),
		.issue_rs1      (issue_rs1),
		.issue_rs2      (issue_rs2),
		.issue_op1      (issue_op1),
		.issue_op2      (issue_op2),
		.issue_pc       (issue_pc),
		.issue_imm      (issue_imm),
		.dispatch_valid (dispatch_valid),
		.dispatch_thread(dispatch_thread),
		.issue_ack      (issue_ack),
		.head_valid     (head_valid),
		.wb_valid       (wb_valid),
		.wb_addr        (wb_addr),
		.wb_data        (wb_data),
		.jump_en        (jump_en),
		.jump_addr      (jump_addr)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout: tests did not finish within %0d cycles", max_cycles);
			$display("Checks failed");
			$fatal(1, "timeout");
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;  // drive point
	endtask

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s, got %h expected %h", $time, msg, actual, expected);
			$display("Checks failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	function automatic data_t expect_alu(alu_op_e op, data_t a, data_t b);
		case (op)
			op_add:  return a + b;
			op_sub:  return a - b;
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			default: return '0;
		endcase
	endfunction

	task automatic issue_start(input int t, input alu_op_e op, input reg_addr_t rd,
			input reg_addr_t rs1, input reg_addr_t rs2, input data_t op1, input data_t op2,
			input data_t pc, input data_t imm);
		issue_op[t]  = op;
		issue_rd[t]  = rd;
		issue_rs1[t] = rs1;
		issue_rs2[t] = rs2;
		issue_op1[t] = op1;
		issue_op2[t] = op2;
		issue_pc[t]  = pc;
		issue_imm[t] = imm;
		issue_req[t] = 1'b1;
	endtask

	task automatic issue_finish(input int t);
		while (!issue_ack[t]) begin
			next_cycle();
		end
		issue_req[t] = 1'b0;
		while (issue_ack[t]) begin
			next_cycle();
		end
	endtask

	task automatic issue_instr(input int t, input alu_op_e op, input reg_addr_t rd,
			input reg_addr_t rs1, input reg_addr_t rs2, input data_t op1, input data_t op2,
			input data_t pc, input data_t imm);
		issue_start(t, op, rd, rs1, rs2, op1, op2, pc, imm);
		issue_finish(t);
	endtask

	task automatic dispatch_one(input int k, input int t);
		dispatch_valid[k]  = 1'b1;
		dispatch_thread[k] = thread_id_t'(t);
		next_cycle();
		dispatch_valid[k] = 1'b0;
	endtask

	task automatic dispatch_two(input int t0, input int t1);
		dispatch_valid[0]  = 1'b1;
		dispatch_thread[0] = thread_id_t'(t0);
		dispatch_valid[1]  = 1'b1;
		dispatch_thread[1] = thread_id_t'(t1);
		next_cycle();
		dispatch_valid[0] = 1'b0;
		dispatch_valid[1] = 1'b0;
	endtask

	task automatic check_wb_now(input int t, input reg_addr_t rd, input data_t data);
		check_eq(wb_valid[t], 1'b1, "wb_valid expected");
		check_eq(wb_addr[t], rd, "wb_addr");
		check_eq(wb_data[t], data, "wb_data");
		check_eq(jump_en[t], 1'b0, "no jump on arithmetic op");
	endtask

	task automatic check_wb(input int t, input reg_addr_t rd, input data_t data);
		@(negedge clk);
		check_wb_now(t, rd, data);
		next_cycle();
	endtask

	task automatic check_quiet(input int t);
		@(negedge clk);
		check_eq(wb_valid[t], 1'b0, "no writeback expected");
		check_eq(jump_en[t], 1'b0, "no jump expected");
		next_cycle();
	endtask

	task automatic test_reset();
		@(negedge clk);
		for (int t = 0; t < num_threads; t++) begin
			check_eq(issue_ack[t], 1'b0, "issue_ack low after reset");
			check_eq(head_valid[t], 1'b0, "head_valid low after reset");
			check_eq(wb_valid[t], 1'b0, "wb_valid low after reset");
			check_eq(jump_en[t], 1'b0, "jump_en low after reset");
		end
		next_cycle();
	endtask

	task automatic test_arith();
		alu_op_e ops [5];
		data_t   a;
		data_t   b;
		ops = '{op_add, op_sub, op_and, op_or, op_xor};
		for (int i = 0; i < 5; i++) begin
			a = $random(seed);
			b = $random(seed);
			issue_instr(i % num_threads, ops[i], reg_addr_t'(5 + i), '0, '0, a, b, '0, '0);
			dispatch_one(i % num_alus, i % num_threads);
			check_wb(i % num_threads, reg_addr_t'(5 + i), expect_alu(ops[i], a, b));
		end
	endtask

	task automatic test_backpressure();
		data_t a [4];
		data_t b [4];
		for (int i = 0; i < 4; i++) begin
			a[i] = $random(seed);
			b[i] = $random(seed);
		end
		for (int i = 0; i < 3; i++) begin
			issue_instr(1, op_add, reg_addr_t'(10 + i), '0, '0, a[i], b[i], '0, '0);
		end
		issue_start(1, op_add, 5'd13, '0, '0, a[3], b[3], '0, '0);
		repeat (10) begin
			next_cycle();
			check_eq(issue_ack[1], 1'b0, "full queue must withhold ack");
		end
		dispatch_one(0, 1);
		check_eq(issue_ack[1], 1'b1, "ack once a pop frees an entry");
		check_wb(1, 5'd10, a[0] + b[0]);
		issue_finish(1);
		for (int i = 1; i < 4; i++) begin  // results in issue order
			dispatch_one(0, 1);
			check_wb(1, reg_addr_t'(10 + i), a[i] + b[i]);
		end
	endtask

	task automatic test_forward(input bit gap);
		data_t a;
		data_t b;
		data_t c;
		a = $random(seed);
		b = $random(seed);
		c = $random(seed);
		issue_instr(2, op_add, 5'd7, '0, '0, a, b, '0, '0);
		issue_instr(2, op_sub, 5'd8, 5'd7, '0, 32'hdead_beef, c, '0, '0);  // stale op1
		dispatch_one(0, 2);
		if (gap) begin
			check_wb(2, 5'd7, a + b);
		end
		dispatch_one(1, 2);
		check_wb(2, 5'd8, (a + b) - c);
	endtask

	task automatic test_branch_taken();
		data_t x;
		data_t pc;
		data_t imm;
		x   = $random(seed);
		pc  = 32'h0000_2000;
		imm = 32'h0000_0040;
		issue_instr(3, op_beq, 5'd23, '0, '0, x, x, pc, imm);
		issue_instr(3, op_add, 5'd20, '0, '0, x, x, '0, '0);
		issue_instr(3, op_add, 5'd21, '0, '0, x, x, '0, '0);
		dispatch_one(0, 3);
		@(negedge clk);
		check_eq(jump_en[3], 1'b1, "taken beq raises jump_en");
		check_eq(jump_addr[3], pc + imm, "jump target is pc plus imm");
		check_eq(wb_valid[3], 1'b0, "branch writes no register");
		check_eq(head_valid[3], 1'b0, "head hidden while branch in flight");
		next_cycle();
		@(negedge clk);
		check_eq(head_valid[3], 1'b0, "queue empty after flush");
		next_cycle();
		dispatch_one(0, 3);
		check_quiet(3);
	endtask

	task automatic test_branch_not_taken();
		data_t x;
		data_t y;
		x = $random(seed);
		y = $random(seed);
		issue_instr(3, op_bne, 5'd24, '0, '0, x, x, 32'h0000_3000, 32'h0000_0010);
		issue_instr(3, op_add, 5'd22, '0, '0, x, y, '0, '0);
		dispatch_one(1, 3);
		check_quiet(3);
		dispatch_one(1, 3);
		check_wb(3, 5'd22, x + y);  // fall-through path survives
	endtask

	task automatic test_parallel();
		data_t a0;
		data_t b0;
		data_t a1;
		data_t b1;
		a0 = $random(seed);
		b0 = $random(seed);
		a1 = $random(seed);
		b1 = $random(seed);
		issue_instr(0, op_xor, 5'd3, '0, '0, a0, b0, '0, '0);
		issue_instr(1, op_and, 5'd4, '0, '0, a1, b1, '0, '0);
		dispatch_two(1, 0);
		@(negedge clk);
		check_wb_now(0, 5'd3, a0 ^ b0);
		check_wb_now(1, 5'd4, a1 & b1);
		next_cycle();
	endtask

	initial begin
		seed = 81195;
		clk  = 1'b0;
		rst  = 1'b0;
		for (int t = 0; t < num_threads; t++) begin
			issue_req[t] = 1'b0;
			issue_op[t]  = op_add;
			issue_rd[t]  = '0;
			issue_rs1[t] = '0;
			issue_rs2[t] = '0;
			issue_op1[t] = '0;
			issue_op2[t] = '0;
			issue_pc[t]  = '0;
			issue_imm[t] = '0;
		end
		for (int k = 0; k < num_alus; k++) begin
			dispatch_valid[k]  = 1'b0;
			dispatch_thread[k] = '0;
		end
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b1;
		test_reset();
		test_arith();
		test_backpressure();
		test_forward(1'b0);
		test_forward(1'b1);
		test_branch_taken();
		test_branch_not_taken();
		test_parallel();
		$display("All checks passed");
		$finish;
	end

endmodule

// File: filelist.f
common/ex_pkg.sv
queue/thread_queue.sv
logic/dispatch_select.sv
logic/alu.sv
logic/result_route.sv
logic/ex_top.sv
sim/ex_sva.sv
sim/tb_ex_top.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - common/ex_pkg.sv
      - queue/thread_queue.sv
      - logic/dispatch_select.sv
      - logic/alu.sv
      - logic/result_route.sv
      - logic/ex_top.sv
  - target: simulation
    files:
      - sim/ex_sva.sv
      - sim/tb_ex_top.sv
